// ==== vlog.f ====
hdl/cpu_types_pkg.sv
hdl/micro_cycle_pkg.sv
hdl/reg_bus_if.sv
hdl/bus_transfer_ctrl.sv
hdl/data_regs.sv
hdl/index_regs.sv
hdl/nibble_regfile_top.sv
test/regfile_checker.sv
test/regfile_tb.sv

// ==== Makefile ====
TOP := regfile_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f vlog.f --top-module $(TOP) -o $(TOP)

run: compile
	@out="$$(./obj_dir/$(TOP))"; echo "$$out"; echo "$$out" | grep -q "STATUS: PASS"

clean:
	rm -rf obj_dir

// ==== test/regfile_tb.sv ====
`timescale 1ns/100ps

module regfile_tb;

  localparam int RESET_CYCLES   = 8;
  // The sequence below runs just under 70 transfers
  localparam int MAX_TRANSFERS  = 80;
  localparam int TIMEOUT_CYCLES =
    MAX_TRANSFERS * (micro_cycle_pkg::TRANSFER_CYCLES + 1) + RESET_CYCLES;

  logic                     clk;
  logic                     rst_n;
  logic                     start;
  cpu_types_pkg::reg_sel_t  rd_sel;
  cpu_types_pkg::reg_sel_t  wr_sel;
  cpu_types_pkg::inc_sel_t  inc_sel;
  logic [7:0]               imm;
  cpu_types_pkg::nibble_t   alu_result;
  logic                     alu_carry;
  logic                     alu_zero;
  cpu_types_pkg::nibble_t   mem_rdata;
  logic                     busy;
  cpu_types_pkg::mem_addr_t mem_addr;
  cpu_types_pkg::nibble_t   mem_wdata;
  logic                     mem_we;
  cpu_types_pkg::nibble_t   flags;

  // External nibble memory
  cpu_types_pkg::nibble_t   mem [4096];

  // Seen during the last transfer
  cpu_types_pkg::mem_addr_t seen_addr;
  cpu_types_pkg::nibble_t   seen_wdata;
  logic                     seen_we;

  int                       cycles;
  cpu_types_pkg::nibble_t   idx_val [8];
  cpu_types_pkg::nibble_t   a_v;
  cpu_types_pkg::nibble_t   b_v;
  cpu_types_pkg::nibble_t   ta_v;
  cpu_types_pkg::nibble_t   exp_f;
  cpu_types_pkg::mem_addr_t x_m;
  cpu_types_pkg::mem_addr_t y_m;
  cpu_types_pkg::mem_addr_t sp_m;

  nibble_regfile_top dut (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  initial begin
    cycles = 0;
    forever begin
      @(posedge clk);
      cycles++;
      if (cycles > TIMEOUT_CYCLES)
        abort("Timeout, the test sequence did not finish within the cycle limit");
    end
  end

  // Synchronous read, write on mem_we
  always @(posedge clk) begin
    if (mem_we)
      mem[mem_addr] <= mem_wdata;
    mem_rdata <= mem[mem_addr];
  end

  // --------------------------------------------------
  // Reporting
  // --------------------------------------------------
  task automatic abort(input string why);
    $display("%s", why);
    $display("STATUS: FAIL");
    $fatal(1, "Run stopped at the first error");
  endtask

  task automatic mismatch(input string name, input logic [11:0] got, input logic [11:0] exp);
    abort($sformatf("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp));
  endtask

  // --------------------------------------------------
  // Transfers, called on a falling edge
  // --------------------------------------------------
  task automatic transfer(input cpu_types_pkg::reg_sel_t src,
                          input cpu_types_pkg::reg_sel_t dst,
                          input cpu_types_pkg::inc_sel_t inc,
                          input logic [7:0] imm_val);
    int n;
    rd_sel  = src;
    wr_sel  = dst;
    inc_sel = inc;
    imm     = imm_val;
    start   = 1'b1;
    @(negedge clk);
    start = 1'b0;
    n = 0;
    while (busy) begin
      if (n == 0) begin
        seen_addr = mem_addr;
      end else begin
        seen_we    = mem_we;
        seen_wdata = mem_wdata;
      end
      n++;
      @(negedge clk);
    end
  endtask

  task automatic load_imm(input cpu_types_pkg::reg_sel_t dst, input cpu_types_pkg::nibble_t val);
    transfer(cpu_types_pkg::REG_IMML, dst, cpu_types_pkg::INC_NONE, {4'h0, val});
  endtask

  // Read back through a memory write to address 0x00F
  task automatic check_reg(input cpu_types_pkg::reg_sel_t src,
                           input cpu_types_pkg::nibble_t exp, input string name);
    transfer(src, cpu_types_pkg::REG_MN, cpu_types_pkg::INC_NONE, 8'h0F);
    assert (seen_we) else abort($sformatf("No memory write while reading back %s", name));
    assert (seen_wdata == exp) else mismatch(name, 12'(seen_wdata), 12'(exp));
  endtask

  task automatic load_addr(input cpu_types_pkg::reg_sel_t lo, input logic [11:0] val,
                           input int nibbles);
    for (int k = 0; k < nibbles; k++)
      load_imm(cpu_types_pkg::reg_sel_t'(lo + k), val[4*k +: 4]);
  endtask

  task automatic addr_check(input cpu_types_pkg::reg_sel_t src,
                            input cpu_types_pkg::reg_sel_t dst,
                            input cpu_types_pkg::inc_sel_t inc,
                            input cpu_types_pkg::mem_addr_t exp);
    transfer(src, dst, inc, 8'h07);
    assert (seen_addr == exp) else mismatch("mem_addr", seen_addr, exp);
  endtask

  task automatic mem_read_check(input cpu_types_pkg::reg_sel_t src,
                                input cpu_types_pkg::mem_addr_t exp_addr);
    cpu_types_pkg::nibble_t exp;
    exp = mem[exp_addr];
    addr_check(src, cpu_types_pkg::REG_TB, cpu_types_pkg::INC_NONE, exp_addr);
    check_reg(cpu_types_pkg::REG_TB, exp, "TB");
  endtask

  // --------------------------------------------------
  // Test sequence
  // --------------------------------------------------
  initial begin
    void'($urandom(52));
    rst_n      = 1'b0;
    start      = 1'b0;
    rd_sel     = cpu_types_pkg::REG_A;
    wr_sel     = cpu_types_pkg::REG_A;
    inc_sel    = cpu_types_pkg::INC_NONE;
    imm        = 8'h00;
    alu_result = 4'h0;
    alu_carry  = 1'b0;
    alu_zero   = 1'b0;
    mem_rdata <= 4'h0;
    for (int i = 0; i < 4096; i++)
      mem[i] <= cpu_types_pkg::nibble_t'(i[3:0] ^ i[7:4] ^ i[11:8] ^ 4'hA);
    repeat (RESET_CYCLES) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    assert (flags == 4'h0) else mismatch("flags", 12'(flags), 12'h0);

    // Data registers from immediate, ALU and constant sources
    a_v  = cpu_types_pkg::nibble_t'($urandom);
    b_v  = cpu_types_pkg::nibble_t'($urandom);
    ta_v = cpu_types_pkg::nibble_t'($urandom);
    load_imm(cpu_types_pkg::REG_A, a_v);
    transfer(cpu_types_pkg::REG_IMMH, cpu_types_pkg::REG_B, cpu_types_pkg::INC_NONE, {b_v, 4'h0});
    alu_result = ta_v;
    transfer(cpu_types_pkg::REG_ALU, cpu_types_pkg::REG_TA, cpu_types_pkg::INC_NONE, 8'h00);
    transfer(cpu_types_pkg::REG_ONE, cpu_types_pkg::REG_TB, cpu_types_pkg::INC_NONE, 8'h00);
    check_reg(cpu_types_pkg::REG_A, a_v, "A");
    check_reg(cpu_types_pkg::REG_B, b_v, "B");
    check_reg(cpu_types_pkg::REG_TA, ta_v, "TA");
    check_reg(cpu_types_pkg::REG_TB, 4'h1, "TB");
    transfer(cpu_types_pkg::REG_A, cpu_types_pkg::REG_TB, cpu_types_pkg::INC_NONE, 8'h00);
    check_reg(cpu_types_pkg::REG_TB, a_v, "TB");
    transfer(cpu_types_pkg::REG_TA, cpu_types_pkg::REG_A, cpu_types_pkg::INC_NONE, 8'h00);
    check_reg(cpu_types_pkg::REG_A, ta_v, "A");

    // Index nibbles XL through SPH, copied out through B
    for (int i = 0; i < 8; i++) begin
      idx_val[i] = cpu_types_pkg::nibble_t'($urandom);
      load_imm(cpu_types_pkg::reg_sel_t'(cpu_types_pkg::REG_XL + i), idx_val[i]);
    end
    for (int i = 0; i < 8; i++) begin
      transfer(cpu_types_pkg::reg_sel_t'(cpu_types_pkg::REG_XL + i), cpu_types_pkg::REG_B,
               cpu_types_pkg::INC_NONE, 8'h00);
      check_reg(cpu_types_pkg::REG_B, idx_val[i], "B");
    end
    x_m  = {idx_val[2], idx_val[1], idx_val[0]};
    y_m  = {idx_val[5], idx_val[4], idx_val[3]};
    sp_m = {4'h0, idx_val[7], idx_val[6]};

    // Memory reads
    mem_read_check(cpu_types_pkg::REG_MX, x_m);
    mem_read_check(cpu_types_pkg::REG_MY, y_m);
    mem_read_check(cpu_types_pkg::REG_MSP, sp_m);
    mem_read_check(cpu_types_pkg::REG_MN, 12'h007);

    // Memory writes
    a_v = cpu_types_pkg::nibble_t'($urandom);
    load_imm(cpu_types_pkg::REG_A, a_v);
    transfer(cpu_types_pkg::REG_A, cpu_types_pkg::REG_MY, cpu_types_pkg::INC_NONE, 8'h00);
    assert (seen_we) else abort("No memory write for a transfer to MY");
    assert (seen_addr == y_m) else mismatch("mem_addr", seen_addr, y_m);
    assert (seen_wdata == a_v) else mismatch("mem_wdata", 12'(seen_wdata), 12'(a_v));
    assert (mem[y_m] == a_v) else mismatch("mem", 12'(mem[y_m]), 12'(a_v));
    transfer(cpu_types_pkg::REG_ONE, cpu_types_pkg::REG_MN, cpu_types_pkg::INC_NONE, 8'h03);
    assert (mem[3] == 4'h1) else mismatch("mem", 12'(mem[3]), 12'h1);

    // X post-increment, even low byte so plus 1 stays in the page
    x_m = cpu_types_pkg::mem_addr_t'($urandom) & 12'hFFE;
    load_addr(cpu_types_pkg::REG_XL, x_m, 3);
    addr_check(cpu_types_pkg::REG_MX, cpu_types_pkg::REG_A, cpu_types_pkg::INC_X, x_m);
    addr_check(cpu_types_pkg::REG_MX, cpu_types_pkg::REG_A, cpu_types_pkg::INC_NONE,
               x_m + 12'd1);
    // Y wraps inside page 2
    load_addr(cpu_types_pkg::REG_YL, 12'h2FF, 3);
    addr_check(cpu_types_pkg::REG_MY, cpu_types_pkg::REG_A, cpu_types_pkg::INC_Y, 12'h2FF);
    addr_check(cpu_types_pkg::REG_MY, cpu_types_pkg::REG_A, cpu_types_pkg::INC_NONE, 12'h200);
    // SP post-increment, then pre-decrement
    load_addr(cpu_types_pkg::REG_SPL, 12'h040, 2);
    addr_check(cpu_types_pkg::REG_A, cpu_types_pkg::REG_MSP, cpu_types_pkg::INC_SP_INC, 12'h040);
    addr_check(cpu_types_pkg::REG_MSP, cpu_types_pkg::REG_A, cpu_types_pkg::INC_NONE, 12'h041);
    addr_check(cpu_types_pkg::REG_A, cpu_types_pkg::REG_MSP_DEC, cpu_types_pkg::INC_SP_DEC,
               12'h040);
    addr_check(cpu_types_pkg::REG_MSP, cpu_types_pkg::REG_A, cpu_types_pkg::INC_NONE, 12'h040);

    // Flags, only C and Z come from the ALU
    exp_f = 4'hC;
    load_imm(cpu_types_pkg::REG_FLAGS, exp_f);
    assert (flags == exp_f) else mismatch("flags", 12'(flags), 12'(exp_f));
    check_reg(cpu_types_pkg::REG_FLAGS, exp_f, "FLAGS");
    alu_result = 4'h5;
    alu_carry  = 1'b1;
    alu_zero   = 1'b1;
    transfer(cpu_types_pkg::REG_ALU, cpu_types_pkg::REG_A, cpu_types_pkg::INC_NONE, 8'h00);
    assert (flags == exp_f) else mismatch("flags", 12'(flags), 12'(exp_f));
    transfer(cpu_types_pkg::REG_ALU_WITH_FLAGS, cpu_types_pkg::REG_TA,
             cpu_types_pkg::INC_NONE, 8'h00);
    exp_f[cpu_types_pkg::FLAG_C] = 1'b1;
    exp_f[cpu_types_pkg::FLAG_Z] = 1'b1;
    assert (flags == exp_f) else mismatch("flags", 12'(flags), 12'(exp_f));
    check_reg(cpu_types_pkg::REG_TA, 4'h5, "TA");
    alu_carry = 1'b0;
    transfer(cpu_types_pkg::REG_ALU_WITH_FLAGS, cpu_types_pkg::REG_B,
             cpu_types_pkg::INC_NONE, 8'h00);
    exp_f[cpu_types_pkg::FLAG_C] = 1'b0;
    assert (flags == exp_f) else mismatch("flags", 12'(flags), 12'(exp_f));

    $display("STATUS: PASS");
    $finish;
  end

endmodule

// ==== test/regfile_checker.sv ====
`timescale 1ns/100ps

module regfile_checker (
  input logic clk,
  input logic rst_n,
  input logic busy,
  input logic mem_we
);

  // --------------------------------------------------
  // Transfer protocol
  // --------------------------------------------------

  // Busy for exactly fetch plus write
  assert property (@(posedge clk) disable iff (!rst_n)
    $rose(busy) |-> ##(micro_cycle_pkg::TRANSFER_CYCLES - 1) busy ##1 !busy)
    else $error("busy did not last exactly one transfer");

  // Memory write only in the second busy cycle
  assert property (@(posedge clk) disable iff (!rst_n)
    mem_we |-> busy && $past(busy) && !$past(busy, 2))
    else $error("mem_we outside the write cycle");

  assert property (@(posedge clk) !rst_n |=> !busy && !mem_we)
    else $error("busy or mem_we high after reset");

endmodule

bind nibble_regfile_top regfile_checker u_checker (
  .clk    (clk),
  .rst_n  (rst_n),
  .busy   (busy),
  .mem_we (mem_we)
);

// ==== hdl/nibble_regfile_top.sv ====
`timescale 1ns/100ps

module nibble_regfile_top (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     start,
  input  cpu_types_pkg::reg_sel_t  rd_sel,
  input  cpu_types_pkg::reg_sel_t  wr_sel,
  input  cpu_types_pkg::inc_sel_t  inc_sel,
  input  logic [7:0]               imm,
  input  cpu_types_pkg::nibble_t   alu_result,
  input  logic                     alu_carry,
  input  logic                     alu_zero,
  input  cpu_types_pkg::nibble_t   mem_rdata,
  output logic                     busy,
  output cpu_types_pkg::mem_addr_t mem_addr,
  output cpu_types_pkg::nibble_t   mem_wdata,
  output logic                     mem_we,
  output cpu_types_pkg::nibble_t   flags
);

  // One bus per register bank
  reg_bus_if data_bus ();
  reg_bus_if index_bus ();

  bus_transfer_ctrl u_ctrl (
    .clk        (clk),
    .rst_n      (rst_n),
    .start      (start),
    .rd_sel     (rd_sel),
    .wr_sel     (wr_sel),
    .inc_sel    (inc_sel),
    .imm        (imm),
    .alu_result (alu_result),
    .alu_carry  (alu_carry),
    .alu_zero   (alu_zero),
    .mem_rdata  (mem_rdata),
    .busy       (busy),
    .mem_wdata  (mem_wdata),
    .mem_we     (mem_we),
    .data_bus   (data_bus.ctrl),
    .index_bus  (index_bus.ctrl)
  );

  data_regs u_data_regs (
    .clk   (clk),
    .rst_n (rst_n),
    .bus   (data_bus.bank),
    .flags (flags)
  );

  index_regs u_index_regs (
    .clk      (clk),
    .rst_n    (rst_n),
    .bus      (index_bus.bank),
    .mem_addr (mem_addr)
  );

endmodule

// ==== hdl/index_regs.sv ====
`timescale 1ns/100ps

module index_regs (
  input  logic                     clk,
  input  logic                     rst_n,
  reg_bus_if.bank                  bus,
  output cpu_types_pkg::mem_addr_t mem_addr
);

  // Page nibble in [11:8], low byte in [7:0]
  cpu_types_pkg::mem_addr_t x;
  cpu_types_pkg::mem_addr_t y;
  cpu_types_pkg::sp_t       sp;
  cpu_types_pkg::sp_t       sp_dec;

  assign sp_dec = sp - 8'd1;

  // --------------------------------------------------
  // Nibble writes and address updates
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      x  <= 12'h000;
      y  <= 12'h000;
      sp <= 8'h00;
    end else if (bus.wr_stb) begin
      case (bus.wr_sel)
        cpu_types_pkg::REG_XL:  x[3:0]   <= bus.bus_value;
        cpu_types_pkg::REG_XH:  x[7:4]   <= bus.bus_value;
        cpu_types_pkg::REG_XP:  x[11:8]  <= bus.bus_value;
        cpu_types_pkg::REG_YL:  y[3:0]   <= bus.bus_value;
        cpu_types_pkg::REG_YH:  y[7:4]   <= bus.bus_value;
        cpu_types_pkg::REG_YP:  y[11:8]  <= bus.bus_value;
        cpu_types_pkg::REG_SPL: sp[3:0]  <= bus.bus_value;
        cpu_types_pkg::REG_SPH: sp[7:4]  <= bus.bus_value;
        default: ;
      endcase

      // Increment wins over a nibble write to the same register
      case (bus.inc_sel)
        cpu_types_pkg::INC_X:      x  <= {x[11:8], x[7:0] + 8'd1};
        cpu_types_pkg::INC_Y:      y  <= {y[11:8], y[7:0] + 8'd1};
        cpu_types_pkg::INC_SP_INC: sp <= sp + 8'd1;
        cpu_types_pkg::INC_SP_DEC: sp <= sp_dec;
        default: ;
      endcase
    end
  end

  // --------------------------------------------------
  // Read mux
  // --------------------------------------------------
  always_comb begin
    case (bus.rd_sel)
      cpu_types_pkg::REG_XL:  bus.rd_data = x[3:0];
      cpu_types_pkg::REG_XH:  bus.rd_data = x[7:4];
      cpu_types_pkg::REG_XP:  bus.rd_data = x[11:8];
      cpu_types_pkg::REG_YL:  bus.rd_data = y[3:0];
      cpu_types_pkg::REG_YH:  bus.rd_data = y[7:4];
      cpu_types_pkg::REG_YP:  bus.rd_data = y[11:8];
      cpu_types_pkg::REG_SPL: bus.rd_data = sp[3:0];
      cpu_types_pkg::REG_SPH: bus.rd_data = sp[7:4];
      default:                bus.rd_data = 4'd0;
    endcase
  end

  // --------------------------------------------------
  // Memory address generation
  // --------------------------------------------------
  always_comb begin
    case (bus.addr_mode)
      cpu_types_pkg::ADDR_Y:      mem_addr = y;
      cpu_types_pkg::ADDR_SP:     mem_addr = {4'h0, sp};
      // Pre-decrement addresses the new top of stack
      cpu_types_pkg::ADDR_SP_DEC: mem_addr = {4'h0, sp_dec};
      cpu_types_pkg::ADDR_IMM:    mem_addr = {8'h00, bus.imm[3:0]};
      default:                    mem_addr = x;
    endcase
  end

endmodule

// ==== hdl/data_regs.sv ====
`timescale 1ns/100ps

module data_regs (
  input  logic                   clk,
  input  logic                   rst_n,
  reg_bus_if.bank                bus,
  output cpu_types_pkg::nibble_t flags
);

  cpu_types_pkg::nibble_t a;
  cpu_types_pkg::nibble_t b;
  cpu_types_pkg::nibble_t ta;
  cpu_types_pkg::nibble_t tb;

  // --------------------------------------------------
  // Register writes
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      a     <= 4'd0;
      b     <= 4'd0;
      ta    <= 4'd0;
      tb    <= 4'd0;
      flags <= 4'd0;
    end else begin
      if (bus.wr_stb) begin
        case (bus.wr_sel)
          cpu_types_pkg::REG_A:     a     <= bus.bus_value;
          cpu_types_pkg::REG_B:     b     <= bus.bus_value;
          cpu_types_pkg::REG_TA:    ta    <= bus.bus_value;
          cpu_types_pkg::REG_TB:    tb    <= bus.bus_value;
          cpu_types_pkg::REG_FLAGS: flags <= bus.bus_value;
          default: ;
        endcase
      end

      // ALU source with flags, D and I untouched
      if (bus.alu_flags_load) begin
        flags[cpu_types_pkg::FLAG_C] <= bus.alu_carry;
        flags[cpu_types_pkg::FLAG_Z] <= bus.alu_zero;
      end
    end
  end

  // --------------------------------------------------
  // Read mux
  // --------------------------------------------------
  always_comb begin
    case (bus.rd_sel)
      cpu_types_pkg::REG_A:     bus.rd_data = a;
      cpu_types_pkg::REG_B:     bus.rd_data = b;
      cpu_types_pkg::REG_TA:    bus.rd_data = ta;
      cpu_types_pkg::REG_TB:    bus.rd_data = tb;
      cpu_types_pkg::REG_FLAGS: bus.rd_data = flags;
      // Codes owned by other sources
      default:                  bus.rd_data = 4'd0;
    endcase
  end

endmodule

// ==== hdl/bus_transfer_ctrl.sv ====
`timescale 1ns/100ps

module bus_transfer_ctrl (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    start,
  input  cpu_types_pkg::reg_sel_t rd_sel,
  input  cpu_types_pkg::reg_sel_t wr_sel,
  input  cpu_types_pkg::inc_sel_t inc_sel,
  input  logic [7:0]              imm,
  input  cpu_types_pkg::nibble_t  alu_result,
  input  logic                    alu_carry,
  input  logic                    alu_zero,
  input  cpu_types_pkg::nibble_t  mem_rdata,
  output logic                    busy,
  output cpu_types_pkg::nibble_t  mem_wdata,
  output logic                    mem_we,
  reg_bus_if.ctrl                 data_bus,
  reg_bus_if.ctrl                 index_bus
);

  micro_cycle_pkg::micro_cycle_t state;

  // Microinstruction held for the whole transfer
  cpu_types_pkg::reg_sel_t   src_q;
  cpu_types_pkg::reg_sel_t   dst_q;
  cpu_types_pkg::inc_sel_t   inc_q;
  logic [7:0]                imm_q;

  cpu_types_pkg::nibble_t    bus_value;
  cpu_types_pkg::addr_mode_t addr_mode;
  logic                      src_is_mem;
  logic                      dst_is_mem;
  logic                      wr_stb;
  logic                      alu_flags_load;

  function automatic logic is_mem_code(input cpu_types_pkg::reg_sel_t code);
    return code inside {cpu_types_pkg::REG_MX, cpu_types_pkg::REG_MY,
                        cpu_types_pkg::REG_MSP, cpu_types_pkg::REG_MSP_DEC,
                        cpu_types_pkg::REG_MN};
  endfunction

  function automatic cpu_types_pkg::addr_mode_t mode_of(input cpu_types_pkg::reg_sel_t code);
    case (code)
      cpu_types_pkg::REG_MY:      return cpu_types_pkg::ADDR_Y;
      cpu_types_pkg::REG_MSP:     return cpu_types_pkg::ADDR_SP;
      cpu_types_pkg::REG_MSP_DEC: return cpu_types_pkg::ADDR_SP_DEC;
      cpu_types_pkg::REG_MN:      return cpu_types_pkg::ADDR_IMM;
      default:                    return cpu_types_pkg::ADDR_X;
    endcase
  endfunction

  // --------------------------------------------------
  // Micro-cycle sequencer
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= micro_cycle_pkg::CYCLE_IDLE;
      src_q <= cpu_types_pkg::REG_A;
      dst_q <= cpu_types_pkg::REG_A;
      inc_q <= cpu_types_pkg::INC_NONE;
      imm_q <= 8'h00;
    end else begin
      case (state)
        micro_cycle_pkg::CYCLE_IDLE: begin
          // Requests during a transfer are dropped
          if (start) begin
            src_q <= rd_sel;
            dst_q <= wr_sel;
            inc_q <= inc_sel;
            imm_q <= imm;
            state <= micro_cycle_pkg::CYCLE_FETCH;
          end
        end
        micro_cycle_pkg::CYCLE_FETCH: state <= micro_cycle_pkg::CYCLE_WRITE;
        micro_cycle_pkg::CYCLE_WRITE: state <= micro_cycle_pkg::CYCLE_IDLE;
        default:                      state <= micro_cycle_pkg::CYCLE_IDLE;
      endcase
    end
  end

  assign busy   = (state != micro_cycle_pkg::CYCLE_IDLE);
  assign wr_stb = (state == micro_cycle_pkg::CYCLE_WRITE);

  // --------------------------------------------------
  // Source classification and bus mux
  // --------------------------------------------------
  always_comb begin
    case (src_q)
      cpu_types_pkg::REG_A, cpu_types_pkg::REG_B, cpu_types_pkg::REG_TA,
      cpu_types_pkg::REG_TB, cpu_types_pkg::REG_FLAGS:
        bus_value = data_bus.rd_data;
      cpu_types_pkg::REG_XL, cpu_types_pkg::REG_XH, cpu_types_pkg::REG_XP,
      cpu_types_pkg::REG_YL, cpu_types_pkg::REG_YH, cpu_types_pkg::REG_YP,
      cpu_types_pkg::REG_SPL, cpu_types_pkg::REG_SPH:
        bus_value = index_bus.rd_data;
      cpu_types_pkg::REG_MX, cpu_types_pkg::REG_MY, cpu_types_pkg::REG_MSP,
      cpu_types_pkg::REG_MSP_DEC, cpu_types_pkg::REG_MN:
        bus_value = mem_rdata;
      cpu_types_pkg::REG_IMML:            bus_value = imm_q[3:0];
      cpu_types_pkg::REG_IMMH:            bus_value = imm_q[7:4];
      cpu_types_pkg::REG_ALU,
      cpu_types_pkg::REG_ALU_WITH_FLAGS:  bus_value = alu_result;
      cpu_types_pkg::REG_ONE:             bus_value = 4'd1;
      default:                            bus_value = 4'd0;
    endcase
  end

  // Memory side, source wins when both name memory
  assign src_is_mem     = is_mem_code(src_q);
  assign dst_is_mem     = is_mem_code(dst_q);
  assign addr_mode      = src_is_mem ? mode_of(src_q) : mode_of(dst_q);
  assign mem_we         = wr_stb && dst_is_mem;
  assign mem_wdata      = bus_value;
  assign alu_flags_load = wr_stb && (src_q == cpu_types_pkg::REG_ALU_WITH_FLAGS);

  // --------------------------------------------------
  // Drive both register banks
  // --------------------------------------------------
  assign data_bus.rd_sel          = src_q;
  assign data_bus.wr_sel          = dst_q;
  assign data_bus.bus_value       = bus_value;
  assign data_bus.wr_stb          = wr_stb;
  assign data_bus.inc_sel         = inc_q;
  assign data_bus.addr_mode       = addr_mode;
  assign data_bus.imm             = imm_q;
  assign data_bus.alu_flags_load  = alu_flags_load;
  assign data_bus.alu_carry       = alu_carry;
  assign data_bus.alu_zero        = alu_zero;

  assign index_bus.rd_sel         = src_q;
  assign index_bus.wr_sel         = dst_q;
  assign index_bus.bus_value      = bus_value;
  assign index_bus.wr_stb         = wr_stb;
  assign index_bus.inc_sel        = inc_q;
  assign index_bus.addr_mode      = addr_mode;
  assign index_bus.imm            = imm_q;
  assign index_bus.alu_flags_load = alu_flags_load;
  assign index_bus.alu_carry      = alu_carry;
  assign index_bus.alu_zero       = alu_zero;

endmodule

// ==== hdl/reg_bus_if.sv ====
`timescale 1ns/100ps

interface reg_bus_if;

  // Microinstruction fields and bus value from the controller
  cpu_types_pkg::reg_sel_t   rd_sel;
  cpu_types_pkg::reg_sel_t   wr_sel;
  cpu_types_pkg::nibble_t    bus_value;
  logic                      wr_stb;
  cpu_types_pkg::inc_sel_t   inc_sel;
  cpu_types_pkg::addr_mode_t addr_mode;
  logic [7:0]                imm;

  // ALU flag update
  logic                      alu_flags_load;
  logic                      alu_carry;
  logic                      alu_zero;

  // Read value returned by the bank
  cpu_types_pkg::nibble_t    rd_data;

  modport ctrl (
    output rd_sel, wr_sel, bus_value, wr_stb, inc_sel, addr_mode, imm,
    output alu_flags_load, alu_carry, alu_zero,
    input  rd_data
  );

  modport bank (
    input  rd_sel, wr_sel, bus_value, wr_stb, inc_sel, addr_mode, imm,
    input  alu_flags_load, alu_carry, alu_zero,
    output rd_data
  );

endinterface

// ==== hdl/micro_cycle_pkg.sv ====
package micro_cycle_pkg;

  // --------------------------------------------------
  // Micro-sequence of one bus transfer
  // --------------------------------------------------
  typedef enum logic [1:0] {
    CYCLE_IDLE  = 2'd0,
    CYCLE_FETCH = 2'd1,
    CYCLE_WRITE = 2'd2
  } micro_cycle_t;

  // Busy cycles per transfer, fetch plus write
  localparam int TRANSFER_CYCLES = 2;

endpackage

// ==== hdl/cpu_types_pkg.sv ====
package cpu_types_pkg;

  // --------------------------------------------------
  // Data and address widths
  // --------------------------------------------------
  typedef logic [3:0]  nibble_t;
  typedef logic [11:0] mem_addr_t;
  typedef logic [7:0]  sp_t;

  typedef logic [4:0] reg_sel_t;
  typedef logic [2:0] inc_sel_t;
  typedef logic [2:0] addr_mode_t;

  // --------------------------------------------------
  // Bus source and destination codes
  // --------------------------------------------------
  localparam reg_sel_t REG_A              = 5'd0;
  localparam reg_sel_t REG_B              = 5'd1;
  localparam reg_sel_t REG_TA             = 5'd2;
  localparam reg_sel_t REG_TB             = 5'd3;
  localparam reg_sel_t REG_FLAGS          = 5'd4;
  localparam reg_sel_t REG_XL             = 5'd5;
  localparam reg_sel_t REG_XH             = 5'd6;
  localparam reg_sel_t REG_XP             = 5'd7;
  localparam reg_sel_t REG_YL             = 5'd8;
  localparam reg_sel_t REG_YH             = 5'd9;
  localparam reg_sel_t REG_YP             = 5'd10;
  localparam reg_sel_t REG_SPL            = 5'd11;
  localparam reg_sel_t REG_SPH            = 5'd12;
  localparam reg_sel_t REG_IMML           = 5'd13;
  localparam reg_sel_t REG_IMMH           = 5'd14;
  localparam reg_sel_t REG_ALU            = 5'd15;
  localparam reg_sel_t REG_ALU_WITH_FLAGS = 5'd16;
  localparam reg_sel_t REG_ONE            = 5'd17;
  // Memory operands
  localparam reg_sel_t REG_MX             = 5'd18;
  localparam reg_sel_t REG_MY             = 5'd19;
  localparam reg_sel_t REG_MSP            = 5'd20;
  localparam reg_sel_t REG_MSP_DEC        = 5'd21;
  localparam reg_sel_t REG_MN             = 5'd22;

  // Increment selector
  localparam inc_sel_t INC_NONE   = 3'd0;
  localparam inc_sel_t INC_X      = 3'd1;
  localparam inc_sel_t INC_Y      = 3'd2;
  localparam inc_sel_t INC_SP_INC = 3'd3;
  localparam inc_sel_t INC_SP_DEC = 3'd4;

  // Memory address source
  localparam addr_mode_t ADDR_X      = 3'd0;
  localparam addr_mode_t ADDR_Y      = 3'd1;
  localparam addr_mode_t ADDR_SP     = 3'd2;
  localparam addr_mode_t ADDR_SP_DEC = 3'd3;
  localparam addr_mode_t ADDR_IMM    = 3'd4;

  // Bit positions in FLAGS
  localparam int FLAG_C = 0;
  localparam int FLAG_Z = 1;
  localparam int FLAG_D = 2;
  localparam int FLAG_I = 3;

endpackage
